//--- Bender.yml
package:
  name: mem_1r1w

sources:
  - hw/mem_pkg.sv
  - hw/bank_align.sv
  - hw/refresh_sched.sv
  - hw/conflict_cache.sv
  - hw/mem_1r1w_top.sv
  - target: test
    files:
      - tb/phys_bank_model.sv
      - tb/tb_mem_1r1w_top.sv

//--- hw/bank_align.sv
`timescale 1ns/1ps

module bank_align (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         bk_read,
  input  logic                         bk_write,
  input  logic [mem_pkg::bitvrow-1:0]  bk_row,
  input  logic [mem_pkg::width-1:0]    bk_din,
  output logic [mem_pkg::width-1:0]    bk_dout,
  output logic                         mem_read,
  output logic                         mem_write,
  output logic [mem_pkg::bitsrow-1:0]  mem_addr,
  output logic [mem_pkg::phywdth-1:0]  mem_bw,
  output logic [mem_pkg::phywdth-1:0]  mem_din,
  input  logic [mem_pkg::phywdth-1:0]  mem_dout
);

  logic [mem_pkg::bitwrds-1:0] widx;
  logic [mem_pkg::bitwrds-1:0] rd_widx;   // Lane of the read in flight
  mem_pkg::phys_row_u          din_row;
  mem_pkg::phys_row_u          bw_row;
  mem_pkg::phys_row_u          dout_row;

  // Low row bits pick the lane, the rest is the macro row
  assign widx      = bk_row[mem_pkg::bitwrds-1:0];
  assign mem_addr  = bk_row[mem_pkg::bitvrow-1:mem_pkg::bitwrds];
  assign mem_read  = bk_read;
  assign mem_write = bk_write;

  // Only the target lane is enabled, other words keep their contents
  always_comb begin
    din_row = '0;
    bw_row  = '0;
    din_row.word[widx] = bk_din;
    if (bk_write) begin
      bw_row.word[widx] = '1;
    end
  end

  assign mem_din = din_row.flat;
  assign mem_bw  = bw_row.flat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_widx <= '0;
    end else if (bk_read) begin
      rd_widx <= widx;
    end
  end

  assign dout_row = mem_dout;
  assign bk_dout  = dout_row.word[rd_widx];  // Macro data arrives one cycle later

  // Macro is single port
  a_single_port: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write));

endmodule

//--- hw/conflict_cache.sv
`timescale 1ns/1ps

module conflict_cache (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              read,
  input  logic [mem_pkg::bitaddr-1:0]                       rd_addr,
  input  logic                                              write,
  input  logic [mem_pkg::bitaddr-1:0]                       wr_addr,
  input  logic [mem_pkg::width-1:0]                         din,
  output logic                                              rd_vld,
  output logic [mem_pkg::width-1:0]                         rd_dout,
  output logic [mem_pkg::numvbnk-1:0]                       bk_read,
  output logic [mem_pkg::numvbnk-1:0]                       bk_write,
  output logic [mem_pkg::numvbnk-1:0][mem_pkg::bitvrow-1:0] bk_row,
  output logic [mem_pkg::numvbnk-1:0][mem_pkg::width-1:0]   bk_din,
  input  logic [mem_pkg::numvbnk-1:0][mem_pkg::width-1:0]   bk_dout
);

  // ------------------------------
  // Address split
  // ------------------------------
  logic [mem_pkg::bitvbnk-1:0] rd_bnk;
  logic [mem_pkg::bitvrow-1:0] rd_row;
  logic [mem_pkg::bitvbnk-1:0] wr_bnk;
  logic [mem_pkg::bitvrow-1:0] wr_row;

  assign rd_bnk = rd_addr[mem_pkg::bitvbnk-1:0];
  assign rd_row = rd_addr[mem_pkg::bitaddr-1:mem_pkg::bitvbnk];
  assign wr_bnk = wr_addr[mem_pkg::bitvbnk-1:0];
  assign wr_row = wr_addr[mem_pkg::bitaddr-1:mem_pkg::bitvbnk];

  // ------------------------------
  // Cache, one entry per row
  // ------------------------------
  logic [mem_pkg::numvrow-1:0]                       cache_vld;
  logic [mem_pkg::numvrow-1:0][mem_pkg::bitvbnk-1:0] cache_tag;
  logic [mem_pkg::numvrow-1:0][mem_pkg::width-1:0]   cache_dat;

  logic                        conflict;
  logic                        evict;
  logic                        wr_inv;
  logic [mem_pkg::bitvbnk-1:0] ev_bnk;
  logic                        rd_hit;

  assign conflict = read && write && (rd_bnk == wr_bnk);
  assign ev_bnk   = cache_tag[wr_row];
  // Old entry belongs to another bank, which is idle this cycle
  assign evict    = conflict && cache_vld[wr_row] && (ev_bnk != wr_bnk);
  assign wr_inv   = write && !conflict && cache_vld[wr_row] && (ev_bnk == wr_bnk);
  assign rd_hit   = read && cache_vld[rd_row] && (cache_tag[rd_row] == rd_bnk);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cache_vld <= '0;
    end else if (conflict) begin
      cache_vld[wr_row] <= 1'b1;
    end else if (wr_inv) begin
      cache_vld[wr_row] <= 1'b0;  // Bank copy is newer now
    end
  end

  always_ff @(posedge clk) begin
    if (conflict) begin
      cache_tag[wr_row] <= wr_bnk;
      cache_dat[wr_row] <= din;
    end
  end

  // ------------------------------
  // Bank steering
  // ------------------------------
  always_comb begin
    for (int b = 0; b < mem_pkg::numvbnk; b++) begin
      bk_read[b]  = read && (rd_bnk == b);
      bk_write[b] = (write && !conflict && (wr_bnk == b)) || (evict && (ev_bnk == b));
      bk_row[b]   = bk_read[b] ? rd_row : wr_row;   // Eviction reuses the write row
      bk_din[b]   = (evict && (ev_bnk == b)) ? cache_dat[wr_row] : din;
    end
  end

  // ------------------------------
  // Read return
  // ------------------------------
  logic                        rd_hit_q;
  logic [mem_pkg::bitvbnk-1:0] rd_bnk_q;
  logic [mem_pkg::width-1:0]   rd_cdat_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld   <= 1'b0;
      rd_hit_q <= 1'b0;
      rd_bnk_q <= '0;
    end else begin
      rd_vld   <= read;
      rd_hit_q <= rd_hit;
      rd_bnk_q <= rd_bnk;
    end
  end

  always_ff @(posedge clk) begin
    rd_cdat_q <= cache_dat[rd_row];  // Sampled before this cycle's update
  end

  assign rd_dout = rd_hit_q ? rd_cdat_q : bk_dout[rd_bnk_q];

  a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
    (bk_read & bk_write) == '0);

endmodule

//--- hw/mem_1r1w_top.sv
`timescale 1ns/1ps

module mem_1r1w_top (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          read,
  input  logic [mem_pkg::bitaddr-1:0]                   rd_addr,
  input  logic                                          write,
  input  logic [mem_pkg::bitaddr-1:0]                   wr_addr,
  input  logic [mem_pkg::width-1:0]                     din,
  output logic                                          rd_vld,
  output logic [mem_pkg::width-1:0]                     rd_dout,
  input  logic                                          refr,
  output logic [mem_pkg::numvbnk-1:0]                   mem_read,
  output logic [mem_pkg::numvbnk-1:0]                   mem_write,
  output logic [mem_pkg::numvbnk*mem_pkg::bitsrow-1:0]  mem_addr,
  output logic [mem_pkg::numvbnk*mem_pkg::phywdth-1:0]  mem_bw,
  output logic [mem_pkg::numvbnk*mem_pkg::phywdth-1:0]  mem_din,
  input  logic [mem_pkg::numvbnk*mem_pkg::phywdth-1:0]  mem_dout,
  output logic [mem_pkg::numvbnk-1:0]                   ref_en,
  output logic [mem_pkg::bitrrow-1:0]                   ref_row
);

  logic [mem_pkg::numvbnk-1:0]                       bk_read;
  logic [mem_pkg::numvbnk-1:0]                       bk_write;
  logic [mem_pkg::numvbnk-1:0][mem_pkg::bitvrow-1:0] bk_row;
  logic [mem_pkg::numvbnk-1:0][mem_pkg::width-1:0]   bk_din;
  logic [mem_pkg::numvbnk-1:0][mem_pkg::width-1:0]   bk_dout;

  conflict_cache conflict_cache_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (read),
    .rd_addr  (rd_addr),
    .write    (write),
    .wr_addr  (wr_addr),
    .din      (din),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .bk_read  (bk_read),
    .bk_write (bk_write),
    .bk_row   (bk_row),
    .bk_din   (bk_din),
    .bk_dout  (bk_dout)
  );

  // One aligner per macro
  for (genvar g = 0; g < mem_pkg::numvbnk; g++) begin : g_bank
    bank_align bank_align_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .bk_read   (bk_read[g]),
      .bk_write  (bk_write[g]),
      .bk_row    (bk_row[g]),
      .bk_din    (bk_din[g]),
      .bk_dout   (bk_dout[g]),
      .mem_read  (mem_read[g]),
      .mem_write (mem_write[g]),
      .mem_addr  (mem_addr[g*mem_pkg::bitsrow +: mem_pkg::bitsrow]),
      .mem_bw    (mem_bw[g*mem_pkg::phywdth +: mem_pkg::phywdth]),
      .mem_din   (mem_din[g*mem_pkg::phywdth +: mem_pkg::phywdth]),
      .mem_dout  (mem_dout[g*mem_pkg::phywdth +: mem_pkg::phywdth])
    );
  end

  refresh_sched refresh_sched_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .refr    (refr),
    .read    (read),
    .write   (write),
    .ref_en  (ref_en),
    .ref_row (ref_row)
  );

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

  // ------------------------------
  // Logical view
  // ------------------------------
  localparam int width   = 16;                 // Logical word
  localparam int numaddr = 256;
  localparam int bitaddr = 8;

  localparam int numvbnk = 4;                  // Bank = low address bits
  localparam int bitvbnk = 2;
  localparam int numvrow = numaddr / numvbnk;  // Row = upper address bits
  localparam int bitvrow = bitaddr - bitvbnk;

  // ------------------------------
  // Physical view
  // ------------------------------
  localparam int numwrds = 4;                  // Words packed per macro row
  localparam int bitwrds = 2;
  localparam int numsrow = numvrow / numwrds;
  localparam int bitsrow = bitvrow - bitwrds;
  localparam int phywdth = numwrds * width;

  // Refresh walk
  localparam int numrrow = 16;
  localparam int bitrrow = 4;

  // One macro row, seen flat at the macro pins or as word lanes
  typedef union packed {
    logic [phywdth-1:0]             flat;
    logic [numwrds-1:0][width-1:0]  word;
  } phys_row_u;

endpackage

//--- hw/refresh_sched.sv
`timescale 1ns/1ps

module refresh_sched (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         refr,
  input  logic                         read,
  input  logic                         write,
  output logic [mem_pkg::numvbnk-1:0]  ref_en,
  output logic [mem_pkg::bitrrow-1:0]  ref_row
);

  logic [mem_pkg::bitvbnk-1:0] bnk_ptr;
  logic [mem_pkg::bitrrow-1:0] row_cnt;

  // Round robin over banks, row steps once all banks had their turn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_en  <= '0;
      ref_row <= '0;
      bnk_ptr <= '0;
      row_cnt <= '0;
    end else begin
      ref_en <= '0;
      if (refr) begin
        ref_en  <= mem_pkg::numvbnk'(1) << bnk_ptr;
        ref_row <= row_cnt;
        bnk_ptr <= bnk_ptr + 1'b1;
        if (bnk_ptr == mem_pkg::bitvbnk'(mem_pkg::numvbnk - 1)) begin
          if (row_cnt == mem_pkg::bitrrow'(mem_pkg::numrrow - 1)) begin
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Refresh slots are reserved, no access may share them
  a_refr_alone: assert property (@(posedge clk) disable iff (!rst_n)
    refr |-> !(read || write));

endmodule

//--- sources.f
hw/mem_pkg.sv
hw/bank_align.sv
hw/refresh_sched.sv
hw/conflict_cache.sv
hw/mem_1r1w_top.sv
tb/phys_bank_model.sv
tb/tb_mem_1r1w_top.sv

//--- tb/phys_bank_model.sv
`timescale 1ns/1ps

module phys_bank_model (
  input  logic                         clk,
  input  logic                         mem_read,
  input  logic                         mem_write,
  input  logic [mem_pkg::bitsrow-1:0]  mem_addr,
  input  logic [mem_pkg::phywdth-1:0]  mem_bw,
  input  logic [mem_pkg::phywdth-1:0]  mem_din,
  output logic [mem_pkg::phywdth-1:0]  mem_dout
);

  mem_pkg::phys_row_u mem [mem_pkg::numsrow];
  mem_pkg::phys_row_u rd_row;   // Output register of the macro

  initial begin
    for (int r = 0; r < mem_pkg::numsrow; r++) begin
      mem[r].flat = '0;
    end
    rd_row.flat = '0;
  end

  // Single port, so read and write never share a cycle
  always @(posedge clk) begin
    if (mem_read) begin
      rd_row <= mem[mem_addr];
    end
    if (mem_write) begin
      mem[mem_addr].flat <= (mem[mem_addr].flat & ~mem_bw) | (mem_din & mem_bw);
    end
  end

  assign mem_dout = rd_row.flat;

endmodule

//--- tb/tb_mem_1r1w_top.sv
`timescale 1ns/1ps

module tb_mem_1r1w_top;

  localparam int clk_period = 8;
  localparam int num_rand   = 400;

  typedef struct packed {
    logic                         rd;
    logic [mem_pkg::bitaddr-1:0]  ra;
    logic                         wr;
    logic [mem_pkg::bitaddr-1:0]  wa;
    logic [mem_pkg::width-1:0]    d;
    logic                         rf;
    logic [mem_pkg::width-1:0]    exp;   // Read data due one cycle later
  } step_t;

  logic                                          clk;
  logic                                          rst_n;
  logic                                          read;
  logic [mem_pkg::bitaddr-1:0]                   rd_addr;
  logic                                          write;
  logic [mem_pkg::bitaddr-1:0]                   wr_addr;
  logic [mem_pkg::width-1:0]                     din;
  logic                                          rd_vld;
  logic [mem_pkg::width-1:0]                     rd_dout;
  logic                                          refr;
  logic [mem_pkg::numvbnk-1:0]                   mem_read;
  logic [mem_pkg::numvbnk-1:0]                   mem_write;
  logic [mem_pkg::numvbnk*mem_pkg::bitsrow-1:0]  mem_addr;
  logic [mem_pkg::numvbnk*mem_pkg::phywdth-1:0]  mem_bw;
  logic [mem_pkg::numvbnk*mem_pkg::phywdth-1:0]  mem_din;
  logic [mem_pkg::numvbnk*mem_pkg::phywdth-1:0]  mem_dout;
  logic [mem_pkg::numvbnk-1:0]                   ref_en;
  logic [mem_pkg::bitrrow-1:0]                   ref_row;

  step_t                     tbl[$];
  string                     tbl_name[$];
  logic                      tbl_built;
  step_t                     rnd_step;
  logic [mem_pkg::width-1:0] ref_mem [mem_pkg::numaddr];
  int                        ref_bnk;
  int                        ref_rowc;

  // What the DUT owes in the cycle after an apply
  logic                        pend_rd;
  logic [mem_pkg::width-1:0]   pend_dout;
  logic                        pend_refr;
  logic [mem_pkg::numvbnk-1:0] pend_ref_en;
  logic [mem_pkg::bitrrow-1:0] pend_ref_row;
  string                       pend_name;

  mem_1r1w_top mem_1r1w_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .read      (read),
    .rd_addr   (rd_addr),
    .write     (write),
    .wr_addr   (wr_addr),
    .din       (din),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .refr      (refr),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_bw    (mem_bw),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout),
    .ref_en    (ref_en),
    .ref_row   (ref_row)
  );

  for (genvar g = 0; g < mem_pkg::numvbnk; g++) begin : g_macro
    phys_bank_model phys_bank_model_inst (
      .clk       (clk),
      .mem_read  (mem_read[g]),
      .mem_write (mem_write[g]),
      .mem_addr  (mem_addr[g*mem_pkg::bitsrow +: mem_pkg::bitsrow]),
      .mem_bw    (mem_bw[g*mem_pkg::phywdth +: mem_pkg::phywdth]),
      .mem_din   (mem_din[g*mem_pkg::phywdth +: mem_pkg::phywdth]),
      .mem_dout  (mem_dout[g*mem_pkg::phywdth +: mem_pkg::phywdth])
    );
  end

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic add_step(input string name, input logic rd, input logic [7:0] ra,
                          input logic wr, input logic [7:0] wa, input logic [15:0] d,
                          input logic rf, input logic [15:0] exp);
    step_t s;
    s = '{rd: rd, ra: ra, wr: wr, wa: wa, d: d, rf: rf, exp: exp};
    tbl.push_back(s);
    tbl_name.push_back(name);
  endtask

  task automatic build_table();
    add_step("diff_bank", 1, 8'h21, 1, 8'h10, 16'h1111, 0, 16'h0000);
    add_step("diff_bank", 1, 8'h10, 1, 8'h21, 16'h2222, 0, 16'h1111);
    add_step("diff_bank", 1, 8'h21, 0, 8'h00, 16'h0000, 0, 16'h2222);
    add_step("idle", 0, 8'h00, 0, 8'h00, 16'h0000, 0, 16'h0000);
    add_step("lanes", 1, 8'h31, 1, 8'h30, 16'haaaa, 0, 16'h0000);
    add_step("lanes", 1, 8'h35, 1, 8'h34, 16'hbbbb, 0, 16'h0000);
    add_step("lanes", 1, 8'h30, 0, 8'h00, 16'h0000, 0, 16'haaaa);
    add_step("lanes", 1, 8'h34, 0, 8'h00, 16'h0000, 0, 16'hbbbb);
    add_step("conflict_park", 1, 8'h04, 1, 8'h08, 16'h3333, 0, 16'h0000);
    add_step("conflict_park", 1, 8'h08, 0, 8'h00, 16'h0000, 0, 16'h3333);
    add_step("conflict_evict", 1, 8'h0d, 1, 8'h09, 16'h4444, 0, 16'h0000);
    add_step("conflict_evict", 1, 8'h08, 1, 8'h0b, 16'h5555, 0, 16'h3333);
    add_step("conflict_evict", 1, 8'h09, 0, 8'h00, 16'h0000, 0, 16'h4444);
    add_step("conflict_evict", 1, 8'h0b, 0, 8'h00, 16'h0000, 0, 16'h5555);
    add_step("read_before_write", 1, 8'h09, 1, 8'h09, 16'h6666, 0, 16'h4444);
    add_step("read_before_write", 1, 8'h09, 0, 8'h00, 16'h0000, 0, 16'h6666);
    add_step("rewrite_cached", 1, 8'h0a, 1, 8'h09, 16'h7777, 0, 16'h0000);
    add_step("rewrite_cached", 1, 8'h09, 0, 8'h00, 16'h0000, 0, 16'h7777);
    add_step("read_before_write", 1, 8'h30, 1, 8'h30, 16'hcccc, 0, 16'haaaa);
    add_step("read_before_write", 1, 8'h30, 0, 8'h00, 16'h0000, 0, 16'hcccc);
    // Evicted lane must not disturb its neighbour in the macro row
    add_step("evict_lane", 1, 8'h35, 1, 8'h31, 16'hdddd, 0, 16'h0000);
    add_step("evict_lane", 1, 8'h34, 0, 8'h00, 16'h0000, 0, 16'hbbbb);
    add_step("evict_lane", 1, 8'h30, 0, 8'h00, 16'h0000, 0, 16'hcccc);
    add_step("evict_lane", 1, 8'h31, 0, 8'h00, 16'h0000, 0, 16'hdddd);
    for (int i = 0; i < 68; i++) begin
      add_step("refresh_walk", 0, 8'h00, 0, 8'h00, 16'h0000, 1, 16'h0000);
    end
    add_step("idle", 0, 8'h00, 0, 8'h00, 16'h0000, 0, 16'h0000);
  endtask

  // ------------------------------
  // Apply and check
  // ------------------------------
  task automatic apply_step(input step_t s, input string name);
    read    = s.rd;
    rd_addr = s.ra;
    write   = s.wr;
    wr_addr = s.wa;
    din     = s.d;
    refr    = s.rf;
    pend_rd   = s.rd;
    pend_dout = s.exp;
    pend_refr = s.rf;
    pend_name = name;
    if (s.rf) begin
      pend_ref_en  = mem_pkg::numvbnk'(1) << ref_bnk;
      pend_ref_row = mem_pkg::bitrrow'(ref_rowc);
      ref_bnk = (ref_bnk + 1) % mem_pkg::numvbnk;
      if (ref_bnk == 0) ref_rowc = (ref_rowc + 1) % mem_pkg::numrrow;
    end
    if (s.wr) ref_mem[s.wa] = s.d;   // Read above already took the old value
  endtask

  task automatic compare_value(input string test, input string sig,
                               input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL %s: %s expected %h actual %h", test, sig, exp, act);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", sig);
    end
  endtask

  task automatic check_returns();
    compare_value(pend_name, "rd_vld", 32'(pend_rd), 32'(rd_vld));
    if (pend_rd) compare_value(pend_name, "rd_dout", 32'(pend_dout), 32'(rd_dout));
    compare_value(pend_name, "ref_en", pend_refr ? 32'(pend_ref_en) : 32'h0, 32'(ref_en));
    if (pend_refr) compare_value(pend_name, "ref_row", 32'(pend_ref_row), 32'(ref_row));
  endtask

  initial begin
    rst_n   = 1'b0;
    read    = 1'b0;
    rd_addr = '0;
    write   = 1'b0;
    wr_addr = '0;
    din     = '0;
    refr    = 1'b0;
    tbl_built = 1'b0;
    ref_bnk   = 0;
    ref_rowc  = 0;
    pend_rd   = 1'b0;
    pend_refr = 1'b0;
    pend_name = "reset";
    void'($urandom(32'h3ef2_1247));
    for (int a = 0; a < mem_pkg::numaddr; a++) ref_mem[a] = '0;
    build_table();
    tbl_built = 1'b1;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < tbl.size(); i++) begin
      @(negedge clk);
      check_returns();
      apply_step(tbl[i], tbl_name[i]);
    end

    // Random soak, narrow addresses now and then to force conflicts
    for (int n = 0; n < num_rand; n++) begin
      @(negedge clk);
      check_returns();
      rnd_step.rd = 1'($urandom);
      rnd_step.wr = 1'($urandom);
      rnd_step.ra = 8'($urandom);
      rnd_step.wa = 8'($urandom);
      if (1'($urandom)) begin
        rnd_step.ra[7:4] = 4'h0;
        rnd_step.wa[7:4] = 4'h0;
      end
      rnd_step.d   = 16'($urandom);
      rnd_step.rf  = !rnd_step.rd && !rnd_step.wr && 1'($urandom);
      rnd_step.exp = ref_mem[rnd_step.ra];
      apply_step(rnd_step, $sformatf("random_%0d", n));
    end

    @(negedge clk);
    check_returns();
    apply_step('0, "drain");
    @(negedge clk);
    check_returns();

    $display("Simulation passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (tbl_built === 1'b1);
    #((tbl.size() + num_rand + 20) * clk_period);
    $display("Timeout, the run did not finish in time");
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
